//--- sb_defines.svh
// ************************************************
// widths and fixed sbcs fields for the system bus
// access block of the debug module
// include wherever a port or register width is needed
// ************************************************
`ifndef SB_DEFINES_SVH
`define SB_DEFINES_SVH

// bus side
`define SB_ADDR_W      32
`define SB_DATA_W      64

// dmi side
`define DMI_ADDR_W     7
`define DMI_DATA_W     32

// read-only sbcs fields
`define SBCS_VERSION   3'd1        // spec version 1.0
`define SBCS_ASIZE     7'd32       // sbasize in bits
`define SBCS_ACC_MASK  5'b01111    // 8/16/32/64 bit accesses, no 128

`endif

//--- dmi_regs_pkg.sv
// ************************************************
// types seen from the debugger side of the block
// register addresses on the dmi port and the codes
// reported in the sberror field of sbcs
// ************************************************
`include "sb_defines.svh"

package dmi_regs_pkg;

   // dmi addresses of the system bus registers
   typedef enum logic [`DMI_ADDR_W-1:0] {
      ADDR_SBCS       = 7'h38,
      ADDR_SBADDRESS0 = 7'h39,
      ADDR_SBDATA0    = 7'h3c,
      ADDR_SBDATA1    = 7'h3d
   } dmi_addr_t;

   // sberror encodings
   typedef enum logic [2:0] {
      SBERR_NONE  = 3'd0,
      SBERR_BUS   = 3'd2,    // error response on b or r
      SBERR_ALIGN = 3'd3,    // address not aligned to size
      SBERR_SIZE  = 3'd4     // sbaccess not supported
   } sberr_t;

endpackage

//--- sb_bus_pkg.sv
// ************************************************
// types for the bus side of the block
// engine states and the sbaccess size encoding
// ************************************************
package sb_bus_pkg;

   // sbaccess encoding, 4 and above is illegal
   typedef enum logic [2:0] {
      SZ_BYTE  = 3'd0,
      SZ_HALF  = 3'd1,
      SZ_WORD  = 3'd2,
      SZ_DWORD = 3'd3
   } sb_size_t;

   typedef enum logic [3:0] {
      ST_IDLE    = 4'h0,
      ST_CHECK   = 4'h1,    // size and alignment check
      ST_RD_ADDR = 4'h2,
      ST_WR_REQ  = 4'h3,    // aw and w both pending
      ST_WR_ADDR = 4'h4,    // only aw pending
      ST_WR_DATA = 4'h5,    // only w pending
      ST_RD_RESP = 4'h6,
      ST_WR_RESP = 4'h7,
      ST_DONE    = 4'h8
   } sb_state_t;

endpackage

//--- sb_lane.sv
// ************************************************
// byte lane steering for the 64-bit bus
// write data is replicated with a matching strobe,
// read data is pulled down from the addressed lane
// ************************************************
`timescale 1ns/1ps
`include "sb_defines.svh"

module sb_lane (
   input  sb_bus_pkg::sb_size_t      acc_size,
   input  logic [2:0]                addr_low,
   input  logic [`SB_DATA_W-1:0]     acc_wdata,
   input  logic [`SB_DATA_W-1:0]     rdata,
   output logic [`SB_DATA_W-1:0]     wdata,
   output logic [`SB_DATA_W/8-1:0]   wstrb,
   output logic [`SB_DATA_W-1:0]     rd_data
);

   logic [`SB_DATA_W-1:0] rd_shift;

   assign rd_shift = rdata >> {addr_low, 3'b000};   // addressed byte down to bit 0

   always_comb begin
      case (acc_size)
         sb_bus_pkg::SZ_BYTE: begin
            wdata   = {8{acc_wdata[7:0]}};
            wstrb   = 8'h01 << addr_low;
            rd_data = {56'b0, rd_shift[7:0]};
         end
         sb_bus_pkg::SZ_HALF: begin
            wdata   = {4{acc_wdata[15:0]}};
            wstrb   = 8'h03 << {addr_low[2:1], 1'b0};
            rd_data = {48'b0, rd_shift[15:0]};
         end
         sb_bus_pkg::SZ_WORD: begin
            wdata   = {2{acc_wdata[31:0]}};
            wstrb   = 8'h0f << {addr_low[2], 2'b00};
            rd_data = {32'b0, rd_shift[31:0]};
         end
         sb_bus_pkg::SZ_DWORD: begin
            wdata   = acc_wdata;
            wstrb   = 8'hff;
            rd_data = rdata;
         end
         default: begin                                 // illegal size never reaches the bus
            wdata   = '0;
            wstrb   = '0;
            rd_data = '0;
         end
      endcase
   end

endmodule

//--- sb_engine.sv
// ************************************************
// bus access engine for one single-beat transfer
// checks size and alignment, runs the ar/r or the
// aw/w/b handshakes and reports completion
// ************************************************
`timescale 1ns/1ps
`include "sb_defines.svh"

module sb_engine (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      start,
   input  logic                      start_write,
   input  sb_bus_pkg::sb_size_t      acc_size,
   input  logic [`SB_ADDR_W-1:0]     acc_addr,
   input  logic [`SB_DATA_W-1:0]     acc_wdata,
   output logic                      done,
   output logic                      err_valid,
   output dmi_regs_pkg::sberr_t      err_code,
   output logic                      rd_valid,
   output logic [`SB_DATA_W-1:0]     rd_data,
   output logic                      awvalid,
   input  logic                      awready,
   output logic [`SB_ADDR_W-1:0]     awaddr,
   output logic [2:0]                awsize,
   output logic                      wvalid,
   input  logic                      wready,
   output logic [`SB_DATA_W-1:0]     wdata,
   output logic [`SB_DATA_W/8-1:0]   wstrb,
   input  logic                      bvalid,
   output logic                      bready,
   input  logic [1:0]                bresp,
   output logic                      arvalid,
   input  logic                      arready,
   output logic [`SB_ADDR_W-1:0]     araddr,
   output logic [2:0]                arsize,
   input  logic                      rvalid,
   output logic                      rready,
   input  logic [`SB_DATA_W-1:0]     rdata,
   input  logic [1:0]                rresp
);

   sb_bus_pkg::sb_state_t state;
   logic                  wr_q;          // access direction, taken on start
   logic                  unaligned;
   logic                  illegal_size;

   always_comb begin
      case (acc_size)
         sb_bus_pkg::SZ_HALF:  unaligned = acc_addr[0];
         sb_bus_pkg::SZ_WORD:  unaligned = |acc_addr[1:0];
         sb_bus_pkg::SZ_DWORD: unaligned = |acc_addr[2:0];
         default:              unaligned = 1'b0;
      endcase
   end
   assign illegal_size = acc_size[2];   // anything above 64 bits

   // ************************************************
   // state machine
   // ************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= sb_bus_pkg::ST_IDLE;
         wr_q  <= 1'b0;
      end else begin
         case (state)
            sb_bus_pkg::ST_IDLE: begin
               if (start) begin
                  state <= sb_bus_pkg::ST_CHECK;
                  wr_q  <= start_write;
               end
            end
            sb_bus_pkg::ST_CHECK: begin
               if (unaligned | illegal_size)
                  state <= sb_bus_pkg::ST_DONE;
               else if (wr_q)
                  state <= sb_bus_pkg::ST_WR_REQ;
               else
                  state <= sb_bus_pkg::ST_RD_ADDR;
            end
            sb_bus_pkg::ST_RD_ADDR: begin
               if (arready)
                  state <= sb_bus_pkg::ST_RD_RESP;
            end
            sb_bus_pkg::ST_WR_REQ: begin
               if (awready & wready)
                  state <= sb_bus_pkg::ST_WR_RESP;
               else if (awready)
                  state <= sb_bus_pkg::ST_WR_DATA;
               else if (wready)
                  state <= sb_bus_pkg::ST_WR_ADDR;
            end
            sb_bus_pkg::ST_WR_ADDR: begin
               if (awready)
                  state <= sb_bus_pkg::ST_WR_RESP;
            end
            sb_bus_pkg::ST_WR_DATA: begin
               if (wready)
                  state <= sb_bus_pkg::ST_WR_RESP;
            end
            sb_bus_pkg::ST_RD_RESP: begin
               if (rvalid)
                  state <= sb_bus_pkg::ST_DONE;
            end
            sb_bus_pkg::ST_WR_RESP: begin
               if (bvalid)
                  state <= sb_bus_pkg::ST_DONE;
            end
            default: state <= sb_bus_pkg::ST_IDLE;   // done lasts one cycle
         endcase
      end
   end

   // error report, one cycle and always before done
   always_comb begin
      err_valid = 1'b0;
      err_code  = dmi_regs_pkg::SBERR_NONE;
      if (state == sb_bus_pkg::ST_CHECK && unaligned) begin
         err_valid = 1'b1;
         err_code  = dmi_regs_pkg::SBERR_ALIGN;
      end else if (state == sb_bus_pkg::ST_CHECK && illegal_size) begin
         err_valid = 1'b1;
         err_code  = dmi_regs_pkg::SBERR_SIZE;
      end else if ((state == sb_bus_pkg::ST_RD_RESP && rvalid && rresp[1]) ||
                   (state == sb_bus_pkg::ST_WR_RESP && bvalid && bresp[1])) begin
         err_valid = 1'b1;
         err_code  = dmi_regs_pkg::SBERR_BUS;
      end
   end

   assign done     = (state == sb_bus_pkg::ST_DONE);
   assign rd_valid = (state == sb_bus_pkg::ST_RD_RESP) & rvalid & ~rresp[1];

   // ************************************************
   // axi master channels
   // ************************************************
   assign awvalid = (state == sb_bus_pkg::ST_WR_REQ) | (state == sb_bus_pkg::ST_WR_ADDR);
   assign wvalid  = (state == sb_bus_pkg::ST_WR_REQ) | (state == sb_bus_pkg::ST_WR_DATA);
   assign arvalid = (state == sb_bus_pkg::ST_RD_ADDR);
   assign awaddr  = acc_addr;
   assign araddr  = acc_addr;
   assign awsize  = acc_size;
   assign arsize  = acc_size;
   assign bready  = 1'b1;
   assign rready  = 1'b1;

   sb_lane u_lane (
      .acc_size  (acc_size),
      .addr_low  (acc_addr[2:0]),
      .acc_wdata (acc_wdata),
      .rdata     (rdata),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .rd_data   (rd_data)
   );

   // a valid is only withdrawn after its ready, payload held meanwhile
   a_aw_hold: assert property (@(posedge clk) disable iff (rst)
      awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awsize));
   a_w_hold:  assert property (@(posedge clk) disable iff (rst)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));
   a_ar_hold: assert property (@(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arsize));

endmodule

//--- sb_regs.sv
// ************************************************
// system bus registers behind the dmi port
// holds sbcs, sbaddress0, sbdata0 and sbdata1 and
// raises start toward sb_engine on a trigger access
// ************************************************
`timescale 1ns/1ps
`include "sb_defines.svh"

module sb_regs (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    dmi_reg_en,
   input  logic                    dmi_reg_wr_en,
   input  logic [`DMI_ADDR_W-1:0]  dmi_reg_addr,
   input  logic [`DMI_DATA_W-1:0]  dmi_reg_wdata,
   output logic [`DMI_DATA_W-1:0]  dmi_reg_rdata,
   input  logic                    done,
   input  logic                    err_valid,
   input  dmi_regs_pkg::sberr_t    err_code,
   input  logic                    rd_valid,
   input  logic [`SB_DATA_W-1:0]   rd_data,
   output logic                    start,
   output logic                    start_write,
   output sb_bus_pkg::sb_size_t    acc_size,
   output logic [`SB_ADDR_W-1:0]   acc_addr,
   output logic [`SB_DATA_W-1:0]   acc_wdata
);

   // sbcs fields
   logic                   sbbusyerror;
   logic                   sbbusy;
   logic                   sbreadonaddr;
   logic [2:0]             sbaccess;
   logic                   sbautoincrement;
   logic                   sbreadondata;
   logic [2:0]             sberror;
   logic [`DMI_DATA_W-1:0] sbcs;

   logic [`SB_ADDR_W-1:0]  sbaddress0;
   logic [`DMI_DATA_W-1:0] sbdata0;
   logic [`DMI_DATA_W-1:0] sbdata1;

   logic hit_sbcs, hit_addr, hit_data0, hit_data1;
   logic dmi_wr, dmi_rd;
   logic trigger;
   logic busy_access;

   // ************************************************
   // decode
   // ************************************************
   assign dmi_wr    = dmi_reg_en & dmi_reg_wr_en;
   assign dmi_rd    = dmi_reg_en & ~dmi_reg_wr_en;
   assign hit_sbcs  = (dmi_reg_addr == dmi_regs_pkg::ADDR_SBCS);
   assign hit_addr  = (dmi_reg_addr == dmi_regs_pkg::ADDR_SBADDRESS0);
   assign hit_data0 = (dmi_reg_addr == dmi_regs_pkg::ADDR_SBDATA0);
   assign hit_data1 = (dmi_reg_addr == dmi_regs_pkg::ADDR_SBDATA1);

   assign trigger = (dmi_wr & hit_data0) |                  // bus write
                    (dmi_wr & hit_addr & sbreadonaddr) |
                    (dmi_rd & hit_data0 & sbreadondata);
   assign start       = trigger & ~sbbusy & (sberror == 3'd0) & ~sbbusyerror;
   assign start_write = dmi_wr & hit_data0;   // a data0 write is the only bus write

   assign busy_access = sbbusy & dmi_reg_en & (hit_addr | hit_data0 | hit_data1);

   assign sbcs = {`SBCS_VERSION, 6'b0, sbbusyerror, sbbusy, sbreadonaddr, sbaccess,
                  sbautoincrement, sbreadondata, sberror, `SBCS_ASIZE, `SBCS_ACC_MASK};

   assign acc_size  = sb_bus_pkg::sb_size_t'(sbaccess);
   assign acc_addr  = sbaddress0;
   assign acc_wdata = {sbdata1, sbdata0};

   // ************************************************
   // sbcs
   // ************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         sbbusyerror     <= 1'b0;
         sbbusy          <= 1'b0;
         sbreadonaddr    <= 1'b0;
         sbaccess        <= 3'd0;
         sbautoincrement <= 1'b0;
         sbreadondata    <= 1'b0;
         sberror         <= 3'd0;
      end else begin
         if (start)
            sbbusy <= 1'b1;
         else if (done)
            sbbusy <= 1'b0;
         if (busy_access)
            sbbusyerror <= 1'b1;
         else if (dmi_wr & hit_sbcs & ~sbbusy & dmi_reg_wdata[22])
            sbbusyerror <= 1'b0;                    // write one to clear
         if (err_valid)
            sberror <= err_code;
         else if (dmi_wr & hit_sbcs & ~sbbusy)
            sberror <= sberror & ~dmi_reg_wdata[14:12];
         if (dmi_wr & hit_sbcs & ~sbbusy) begin     // config is frozen during an access
            sbreadonaddr    <= dmi_reg_wdata[20];
            sbaccess        <= dmi_reg_wdata[19:17];
            sbautoincrement <= dmi_reg_wdata[16];
            sbreadondata    <= dmi_reg_wdata[15];
         end
      end
   end

   // ************************************************
   // address and data
   // ************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         sbaddress0 <= '0;
         sbdata0    <= '0;
         sbdata1    <= '0;
      end else begin
         if (dmi_wr & hit_addr & ~sbbusy)
            sbaddress0 <= dmi_reg_wdata;
         else if (done & sbautoincrement & (sberror == 3'd0))   // sberror was clear at start
            sbaddress0 <= sbaddress0 + (`SB_ADDR_W'(1) << sbaccess[1:0]);
         if (rd_valid) begin
            sbdata0 <= rd_data[`DMI_DATA_W-1:0];
            sbdata1 <= rd_data[`SB_DATA_W-1:`DMI_DATA_W];
         end else begin
            if (dmi_wr & hit_data0 & ~sbbusy)
               sbdata0 <= dmi_reg_wdata;
            if (dmi_wr & hit_data1 & ~sbbusy)
               sbdata1 <= dmi_reg_wdata;
         end
      end
   end

   // registered read data, held until the next request
   always_ff @(posedge clk) begin
      if (rst) begin
         dmi_reg_rdata <= '0;
      end else if (dmi_reg_en) begin
         case (1'b1)
            hit_sbcs:  dmi_reg_rdata <= sbcs;
            hit_addr:  dmi_reg_rdata <= sbaddress0;
            hit_data0: dmi_reg_rdata <= sbdata0;
            hit_data1: dmi_reg_rdata <= sbdata1;
            default:   dmi_reg_rdata <= '0;
         endcase
      end
   end

   // engine results only arrive while an access is open
   a_result_busy: assert property (@(posedge clk) disable iff (rst)
      (done | err_valid | rd_valid) |-> sbbusy);

endmodule

//--- sb_debug_top.sv
// ************************************************
// system bus access block of the debug module
// dmi register port in, 64-bit axi master out
// ************************************************
`timescale 1ns/1ps
`include "sb_defines.svh"

module sb_debug_top (
   input  logic                      clk,
   input  logic                      rst,
   // dmi
   input  logic                      dmi_reg_en,
   input  logic                      dmi_reg_wr_en,
   input  logic [`DMI_ADDR_W-1:0]    dmi_reg_addr,
   input  logic [`DMI_DATA_W-1:0]    dmi_reg_wdata,
   output logic [`DMI_DATA_W-1:0]    dmi_reg_rdata,
   // axi master
   output logic                      awvalid,
   input  logic                      awready,
   output logic [`SB_ADDR_W-1:0]     awaddr,
   output logic [2:0]                awsize,
   output logic                      wvalid,
   input  logic                      wready,
   output logic [`SB_DATA_W-1:0]     wdata,
   output logic [`SB_DATA_W/8-1:0]   wstrb,
   input  logic                      bvalid,
   output logic                      bready,
   input  logic [1:0]                bresp,
   output logic                      arvalid,
   input  logic                      arready,
   output logic [`SB_ADDR_W-1:0]     araddr,
   output logic [2:0]                arsize,
   input  logic                      rvalid,
   output logic                      rready,
   input  logic [`SB_DATA_W-1:0]     rdata,
   input  logic [1:0]                rresp
);

   logic                   start;
   logic                   start_write;
   sb_bus_pkg::sb_size_t   acc_size;
   logic [`SB_ADDR_W-1:0]  acc_addr;
   logic [`SB_DATA_W-1:0]  acc_wdata;
   logic                   done;
   logic                   err_valid;
   dmi_regs_pkg::sberr_t   err_code;
   logic                   rd_valid;
   logic [`SB_DATA_W-1:0]  rd_data;

   sb_regs u_regs (
      .clk           (clk),
      .rst           (rst),
      .dmi_reg_en    (dmi_reg_en),
      .dmi_reg_wr_en (dmi_reg_wr_en),
      .dmi_reg_addr  (dmi_reg_addr),
      .dmi_reg_wdata (dmi_reg_wdata),
      .dmi_reg_rdata (dmi_reg_rdata),
      .done          (done),
      .err_valid     (err_valid),
      .err_code      (err_code),
      .rd_valid      (rd_valid),
      .rd_data       (rd_data),
      .start         (start),
      .start_write   (start_write),
      .acc_size      (acc_size),
      .acc_addr      (acc_addr),
      .acc_wdata     (acc_wdata)
   );

   sb_engine u_engine (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .start_write (start_write),
      .acc_size    (acc_size),
      .acc_addr    (acc_addr),
      .acc_wdata   (acc_wdata),
      .done        (done),
      .err_valid   (err_valid),
      .err_code    (err_code),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data),
      .awvalid     (awvalid),
      .awready     (awready),
      .awaddr      (awaddr),
      .awsize      (awsize),
      .wvalid      (wvalid),
      .wready      (wready),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .bvalid      (bvalid),
      .bready      (bready),
      .bresp       (bresp),
      .arvalid     (arvalid),
      .arready     (arready),
      .araddr      (araddr),
      .arsize      (arsize),
      .rvalid      (rvalid),
      .rready      (rready),
      .rdata       (rdata),
      .rresp       (rresp)
   );

endmodule

//--- sb_checker.sv
// ************************************************
// checker for the system bus testbench
// compares registered DMI read data with the value
// the driver expects, checks every accepted AXI
// write strobe and access size against the sbaccess
// last written, and watches bready and rready
// ************************************************
`timescale 1ns/1ps
`include "sb_defines.svh"

module sb_checker (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    dmi_reg_en,
   input  logic                    dmi_reg_wr_en,
   input  logic [`DMI_ADDR_W-1:0]  dmi_reg_addr,
   input  logic [`DMI_DATA_W-1:0]  dmi_reg_wdata,
   input  logic [`DMI_DATA_W-1:0]  dmi_reg_rdata,
   input  logic                    exp_check,
   input  logic [`DMI_DATA_W-1:0]  exp_data,
   input  logic                    awvalid,
   input  logic                    awready,
   input  logic [`SB_ADDR_W-1:0]   awaddr,
   input  logic [2:0]              awsize,
   input  logic                    wvalid,
   input  logic                    wready,
   input  logic [`SB_DATA_W/8-1:0] wstrb,
   input  logic                    bready,
   input  logic                    arvalid,
   input  logic                    arready,
   input  logic [2:0]              arsize,
   input  logic                    rready,
   output int                      data_errors,
   output int                      strb_errors,
   output int                      axi_errors
);

   logic                   pending;
   logic [`DMI_DATA_W-1:0] pending_data;
   logic [2:0]             exp_size;      // sbaccess as last written over dmi

   // one strobe bit per byte, the run of bytes aligned down to the size
   function automatic logic [7:0] strobe_for(input logic [2:0] size, input logic [2:0] addr);
      int         nbytes;
      logic [8:0] run;
      logic [2:0] offset;
      nbytes = 1 << size;
      run    = (9'd1 << nbytes) - 9'd1;
      offset = addr & ~3'(nbytes - 1);
      return 8'(run << offset);
   endfunction

   // read request accepted on this edge, data is due after it
   always @(posedge clk) begin
      pending      <= !rst && dmi_reg_en && !dmi_reg_wr_en && exp_check;
      pending_data <= exp_data;
      if (rst)
         exp_size <= 3'd0;
      else if (dmi_reg_en && dmi_reg_wr_en && dmi_reg_addr == dmi_regs_pkg::ADDR_SBCS)
         exp_size <= dmi_reg_wdata[19:17];
   end

   always @(negedge clk) begin
      if (pending && dmi_reg_rdata !== pending_data) begin
         $display("** Error at %0t: dmi_reg_rdata = %h, expected %h",
                  $time, dmi_reg_rdata, pending_data);
         data_errors++;
      end
      if (!rst && wvalid && wready && wstrb !== strobe_for(exp_size, awaddr[2:0])) begin
         $display("** Error at %0t: wstrb = %h, expected %h",
                  $time, wstrb, strobe_for(exp_size, awaddr[2:0]));
         strb_errors++;
      end
      if (!rst && awvalid && awready && awsize !== exp_size) begin
         $display("** Error at %0t: awsize = %0d, expected %0d", $time, awsize, exp_size);
         axi_errors++;
      end
      if (!rst && arvalid && arready && arsize !== exp_size) begin
         $display("** Error at %0t: arsize = %0d, expected %0d", $time, arsize, exp_size);
         axi_errors++;
      end
      if (!rst && (bready !== 1'b1 || rready !== 1'b1)) begin
         $display("** Error at %0t: bready = %b, rready = %b, expected 1 and 1",
                  $time, bready, rready);
         axi_errors++;
      end
   end

endmodule

//--- sb_debug_tb.sv
// ************************************************
// testbench top for the system bus access block
// replays DMI operations from the golden file, models
// a 64-bit AXI memory with random ready delays and
// ends the run with a pass or fail line
// ************************************************
`timescale 1ns/1ps
`include "sb_defines.svh"

module sb_debug_tb;

   localparam int CLK_PERIOD   = 20;
   localparam int MEM_WORDS    = 64;
   localparam int LINE_CYCLES  = 200;     // watchdog budget per golden line

   logic                    clk;
   logic                    rst;
   logic                    dmi_reg_en, dmi_reg_wr_en;
   logic [`DMI_ADDR_W-1:0]  dmi_reg_addr;
   logic [`DMI_DATA_W-1:0]  dmi_reg_wdata, dmi_reg_rdata;
   logic                    awvalid, awready, wvalid, wready, bvalid, bready;
   logic                    arvalid, arready, rvalid, rready;
   logic [`SB_ADDR_W-1:0]   awaddr, araddr;
   logic [2:0]              awsize, arsize;
   logic [`SB_DATA_W-1:0]   wdata, rdata;
   logic [`SB_DATA_W/8-1:0] wstrb;
   logic [1:0]              bresp, rresp;
   logic                    exp_check;
   logic [`DMI_DATA_W-1:0]  exp_data;
   int                      data_errors, strb_errors;
   int                      axi_errors;
   int                      other_errors;

   logic [7:0]              op_q[$];
   logic [31:0]             addr_q[$];
   logic [31:0]             data_q[$];
   logic                    loaded;
   logic [`SB_DATA_W-1:0]   mem [0:MEM_WORDS-1];

   sb_debug_top dut (.*);

   sb_checker chk (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // ************************************************
   // golden file driver
   // ************************************************
   task automatic dmi_op(input logic wr, input logic [6:0] addr, input logic [31:0] data,
                         input logic check);
      dmi_reg_en    = 1'b1;
      dmi_reg_wr_en = wr;
      dmi_reg_addr  = addr;
      dmi_reg_wdata = wr ? data : 32'h0;
      exp_check     = check;
      exp_data      = data;
      @(posedge clk);
      #1;
      dmi_reg_en    = 1'b0;
      dmi_reg_wr_en = 1'b0;
      exp_check     = 1'b0;
   endtask

   task automatic poll_not_busy();
      do begin
         dmi_op(1'b0, 7'h38, 32'h0, 1'b0);
      end while (dmi_reg_rdata[21]);             // sbbusy
   endtask

   task automatic load_golden();
      int         fd;
      int         n;
      string      line;
      logic [7:0] op;
      logic [31:0] a, d;
      fd = $fopen("sb_golden.txt", "r");
      if (fd == 0) begin
         $display("could not open the golden file");
         other_errors++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %h %h", op, a, d);
            if (n == 3 && op != "#") begin
               op_q.push_back(op);
               addr_q.push_back(a);
               data_q.push_back(d);
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      void'($urandom(32'hbe407f75));
      rst = 1'b1;
      dmi_reg_en = 1'b0;
      dmi_reg_wr_en = 1'b0;
      dmi_reg_addr = '0;
      dmi_reg_wdata = '0;
      exp_check = 1'b0;
      exp_data = '0;
      other_errors = 0;
      loaded = 1'b0;
      load_golden();
      loaded = 1'b1;
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;
      foreach (op_q[i]) begin
         case (op_q[i])
            "W": dmi_op(1'b1, addr_q[i][6:0], data_q[i], 1'b0);
            "R": dmi_op(1'b0, addr_q[i][6:0], data_q[i], 1'b1);
            "P": poll_not_busy();
            default: begin
               $display("unknown operation in golden line %0d", i);
               other_errors++;
            end
         endcase
      end
      repeat (2) @(posedge clk);
      $display("errors: read data %0d, write strobe %0d, axi %0d, other %0d",
               data_errors, strb_errors, axi_errors, other_errors);
      if (data_errors + strb_errors + axi_errors + other_errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   // watchdog sized from the number of golden lines
   initial begin
      wait (loaded);
      #((op_q.size() + 1) * LINE_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the golden operations completed");
      $display("Testbench failed");
      $finish;
   end

   // ************************************************
   // AXI memory model
   // ************************************************
   initial begin
      logic [`SB_ADDR_W-1:0]   aw_addr_q, ar_addr_q;
      logic [`SB_DATA_W-1:0]   w_data_q;
      logic [`SB_DATA_W/8-1:0] w_strb_q;
      logic                    aw_got, w_got;
      int                      aw_dly, w_dly, ar_dly;
      for (int i = 0; i < MEM_WORDS; i++)                 // pattern from the byte address
         mem[i] = {32'(i * 8) ^ 32'hdeadbeef, 32'(i * 8)};
      {awready, wready, arready, bvalid, rvalid} = '0;
      {bresp, rresp} = '0;
      rdata = '0;
      {aw_got, w_got} = 2'b00;
      aw_dly = $urandom % 4;
      w_dly  = $urandom % 4;
      ar_dly = $urandom % 4;
      forever begin
         @(posedge clk);
         #1;
         bvalid = 1'b0;
         rvalid = 1'b0;
         if (awready) begin
            awready = 1'b0;
            aw_got  = 1'b1;
         end else if (awvalid && !aw_got) begin
            if (aw_dly == 0) begin
               awready   = 1'b1;
               aw_addr_q = awaddr;
               aw_dly    = $urandom % 4;
            end else
               aw_dly--;
         end
         if (wready) begin
            wready = 1'b0;
            w_got  = 1'b1;
         end else if (wvalid && !w_got) begin
            if (w_dly == 0) begin
               wready   = 1'b1;
               w_data_q = wdata;
               w_strb_q = wstrb;
               w_dly    = $urandom % 4;
            end else
               w_dly--;
         end
         if (aw_got && w_got) begin
            if (!aw_addr_q[31]) begin
               for (int b = 0; b < 8; b++)
                  if (w_strb_q[b])
                     mem[aw_addr_q[8:3]][b*8 +: 8] = w_data_q[b*8 +: 8];
            end
            bvalid = 1'b1;
            bresp  = aw_addr_q[31] ? 2'b10 : 2'b00;
            {aw_got, w_got} = 2'b00;
         end
         if (arready) begin
            arready = 1'b0;
            rvalid  = 1'b1;
            rdata   = mem[ar_addr_q[8:3]];
            rresp   = ar_addr_q[31] ? 2'b10 : 2'b00;
         end else if (arvalid) begin
            if (ar_dly == 0) begin
               arready   = 1'b1;
               ar_addr_q = araddr;
               ar_dly    = $urandom % 4;
            end else
               ar_dly--;
         end
      end
   end

endmodule

//--- sb_golden.txt
# op addr data : W = DMI write, R = DMI read with expected data, P = poll sbcs until not busy
# addr is the DMI register address in hex, data is hex
W 38 00040000
W 39 00000010
W 3c 11223344
P 38 00000000
W 38 00060000
W 39 00000018
W 3d cafef00d
W 3c 01234567
P 38 00000000
W 38 00140000
W 39 00000010
P 38 00000000
R 3c 11223344
R 3d 00000000
W 38 00160000
W 39 00000018
P 38 00000000
R 3c 01234567
R 3d cafef00d
R 38 2016040f
W 38 00060000
W 39 00000020
W 3d 88776655
W 3c 44332211
P 38 00000000
W 38 00118000
W 39 00000020
P 38 00000000
R 3c 00000011
P 38 00000000
R 3c 00000022
P 38 00000000
R 3c 00000033
P 38 00000000
R 3c 00000044
P 38 00000000
R 3c 00000055
P 38 00000000
R 3c 00000066
P 38 00000000
R 3c 00000077
P 38 00000000
R 3c 00000088
P 38 00000000
R 39 00000029
W 38 00138000
W 39 00000024
P 38 00000000
R 3c 00006655
P 38 00000000
R 3c 00008877
P 38 00000000
R 39 0000002a
W 38 00158000
W 39 00000010
P 38 00000000
R 3c 11223344
P 38 00000000
R 3c deadbeff
P 38 00000000
W 38 00140000
W 39 00000012
P 38 00000000
R 38 2014340f
W 39 00000010
R 38 2014340f
R 39 00000010
W 38 00147000
R 38 2014040f
W 38 00180000
W 39 00000010
P 38 00000000
R 38 2018440f
W 38 00147000
W 39 80000000
P 38 00000000
R 38 2014240f
W 38 00007000
R 38 2000040f
W 38 00040000
W 39 00000030
W 3c aaaa5555
W 3c 12345678
P 38 00000000
R 3c aaaa5555
R 38 2044040f
W 38 00440000
R 38 2004040f
W 38 00140000
W 39 00000030
P 38 00000000
R 3c aaaa5555

//--- sb_debug_top.f
+incdir+.
dmi_regs_pkg.sv
sb_bus_pkg.sv
sb_lane.sv
sb_engine.sv
sb_regs.sv
sb_debug_top.sv
sb_checker.sv
sb_debug_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the system bus testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sb_debug_top.f --top-module sb_debug_tb -o sb_sim \
   && ./obj_dir/sb_sim > sim.log 2>&1 \
   || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Testbench passed$" sim.log && exit 0 || exit 1
